// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= tb_axi_spi
RTL_TOP   ?= axi_spi_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || { echo "no pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_axi_spi.sv ====
`include "axi_spi_defs.svh"

module tb_axi_spi;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned MAX_BYTES      = 24;
  localparam int unsigned BYTE_CLKS      = 8 * 16;  // one byte at ratio 3
  localparam int unsigned BUS_MARGIN     = 16000;   // register traffic and polling
  localparam int unsigned TIMEOUT_CYCLES = MAX_BYTES * BYTE_CLKS + BUS_MARGIN;

  logic                fixed_clk = 1'b0;
  logic                axi_aresetn;
  axi_lite_pkg::id_t   axi_awid;
  axi_lite_pkg::addr_t axi_awaddr;
  logic                axi_awvalid;
  logic                axi_awready;
  axi_lite_pkg::data_t axi_wdata;
  axi_lite_pkg::strb_t axi_wstrb;
  logic                axi_wvalid;
  logic                axi_wready;
  axi_lite_pkg::id_t   axi_bid;
  axi_lite_pkg::resp_t axi_bresp;
  logic                axi_bvalid;
  logic                axi_bready;
  axi_lite_pkg::id_t   axi_arid;
  axi_lite_pkg::addr_t axi_araddr;
  logic                axi_arvalid;
  logic                axi_arready;
  axi_lite_pkg::id_t   axi_rid;
  axi_lite_pkg::data_t axi_rdata;
  axi_lite_pkg::resp_t axi_rresp;
  logic                axi_rvalid;
  logic                axi_rready;
  logic                spi_clk;
  logic                spi_cs_n;
  logic                spi_mosi;

  int unsigned         cycles = 0;
  int unsigned         errors = 0;
  int unsigned         checks = 0;
  int unsigned         tests = 0;
  logic [31:0]         lcg_state = 32'ha676_5b1e;
  spi_pkg::spi_data_t  mosi_q[$];
  spi_pkg::spi_data_t  mosi_sh = '0;
  int unsigned         mosi_bits = 0;

  axi_spi_top DUT (
    .fixed_clk_i   (fixed_clk),
    .axi_aresetn_i (axi_aresetn),
    .axi_awid_i    (axi_awid),
    .axi_awaddr_i  (axi_awaddr),
    .axi_awvalid_i (axi_awvalid),
    .axi_awready_o (axi_awready),
    .axi_wdata_i   (axi_wdata),
    .axi_wstrb_i   (axi_wstrb),
    .axi_wvalid_i  (axi_wvalid),
    .axi_wready_o  (axi_wready),
    .axi_bid_o     (axi_bid),
    .axi_bresp_o   (axi_bresp),
    .axi_bvalid_o  (axi_bvalid),
    .axi_bready_i  (axi_bready),
    .axi_arid_i    (axi_arid),
    .axi_araddr_i  (axi_araddr),
    .axi_arvalid_i (axi_arvalid),
    .axi_arready_o (axi_arready),
    .axi_rid_o     (axi_rid),
    .axi_rdata_o   (axi_rdata),
    .axi_rresp_o   (axi_rresp),
    .axi_rvalid_o  (axi_rvalid),
    .axi_rready_i  (axi_rready),
    .spi_clk_o     (spi_clk),
    .spi_cs_n_o    (spi_cs_n),
    .spi_mosi_o    (spi_mosi),
    .spi_miso_i    (spi_mosi)   // loopback
  );

  always #4 fixed_clk = ~fixed_clk;

  always @(posedge fixed_clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // mosi bits in wire order, first bit lands in the msb
  always @(posedge spi_clk) begin
    mosi_sh = {mosi_sh[`SPI_DATA_W-2:0], spi_mosi};
    mosi_bits = mosi_bits + 1;
    if (mosi_bits == `SPI_DATA_W) begin
      mosi_q.push_back(mosi_sh);
      mosi_bits = 0;
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic spi_pkg::spi_data_t reverse_bits(input spi_pkg::spi_data_t d);
    spi_pkg::spi_data_t r;
    for (int i = 0; i < `SPI_DATA_W; i++) begin
      r[i] = d[`SPI_DATA_W-1-i];
    end
    return r;
  endfunction

  // expected CR after a strobed write
  function automatic axi_lite_pkg::data_t cr_after_write(input axi_lite_pkg::data_t old,
                                                         input axi_lite_pkg::data_t data,
                                                         input axi_lite_pkg::strb_t strb);
    axi_lite_pkg::data_t r;
    r = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        r[8*i +: 8] = data[8*i +: 8];
      end
    end
    r[`CR_TX_RST_BIT] = 1'b0;  // fifo reset bits read as 0
    r[`CR_RX_RST_BIT] = 1'b0;
    return r;
  endfunction

  task automatic check_data(input string name, input axi_lite_pkg::data_t got,
                            input axi_lite_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input spi_pkg::spi_data_t got,
                            input spi_pkg::spi_data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input axi_lite_pkg::resp_t got,
                            input axi_lite_pkg::resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_id(input string name, input axi_lite_pkg::id_t got,
                          input axi_lite_pkg::id_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic axi_write(input axi_lite_pkg::addr_t addr, input axi_lite_pkg::data_t data,
                           input axi_lite_pkg::strb_t strb);
    @(posedge fixed_clk);
    axi_awid    <= axi_awid + axi_lite_pkg::id_t'(1);
    axi_awaddr  <= addr;
    axi_wdata   <= data;
    axi_wstrb   <= strb;
    axi_awvalid <= 1'b1;
    axi_wvalid  <= 1'b1;
    do begin
      @(posedge fixed_clk);
    end while (!(axi_awready && axi_wready));
    axi_awvalid <= 1'b0;
    axi_wvalid  <= 1'b0;
    while (!axi_bvalid) begin  // bready is always high
      @(posedge fixed_clk);
    end
    check_resp("bresp", axi_bresp, 2'b00);
    check_id("bid", axi_bid, axi_awid);
  endtask

  task automatic axi_read(input axi_lite_pkg::addr_t addr, output axi_lite_pkg::data_t data);
    @(posedge fixed_clk);
    axi_arid    <= axi_arid + axi_lite_pkg::id_t'(1);
    axi_araddr  <= addr;
    axi_arvalid <= 1'b1;
    do begin
      @(posedge fixed_clk);
    end while (!axi_arready);
    axi_arvalid <= 1'b0;
    while (!axi_rvalid) begin
      @(posedge fixed_clk);
    end
    data = axi_rdata;
    check_resp("rresp", axi_rresp, 2'b00);
    check_id("rid", axi_rid, axi_arid);
  endtask

  task automatic expect_reg(input string name, input axi_lite_pkg::addr_t addr,
                            input axi_lite_pkg::data_t exp);
    axi_lite_pkg::data_t d;
    axi_read(addr, d);
    check_data(name, d, exp);
  endtask

  task automatic wait_rx_count(input int unsigned n);
    axi_lite_pkg::data_t d;
    do begin
      axi_read(`SPI_RFOR, d);
    end while (d < n);
    check_data("RFOR", d, n);
  endtask

  task automatic report_test(input string name, input int unsigned err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %-20s ok", name);
    end else begin
      $display("test %-20s %0d errors", name, errors - err_before);
    end
  endtask

  task automatic check_reset_state();
    expect_reg("CR", `SPI_CR, 32'h0);
    expect_reg("SR", `SPI_SR, 32'h5);  // both fifos empty
    expect_reg("SSR", `SPI_SSR, 32'h1);
    expect_reg("RCLK", `SPI_RCLK, 32'h0);
    expect_reg("TFOR", `SPI_TFOR, 32'h0);
    expect_reg("RFOR", `SPI_RFOR, 32'h0);
    expect_reg("unmapped", 7'h10, 32'h6162_6364);
    if (spi_cs_n !== 1'b1 || spi_clk !== 1'b0) begin
      errors++;
      $display("spi_cs_n_o or spi_clk_o not at idle level after reset");
    end
  endtask

  task automatic test_reset();
    int unsigned e0;
    e0 = errors;
    check_reset_state();
    report_test("reset values", e0);
  endtask

  task automatic test_strobes();
    axi_lite_pkg::data_t cr;
    int unsigned         e0;
    e0 = errors;
    cr = cr_after_write(32'h0, 32'hA5A5_A5A5, 4'b0101);
    axi_write(`SPI_CR, 32'hA5A5_A5A5, 4'b0101);
    expect_reg("CR", `SPI_CR, cr);
    cr = cr_after_write(cr, 32'h5A5A_5A5A, 4'b1010);
    axi_write(`SPI_CR, 32'h5A5A_5A5A, 4'b1010);
    expect_reg("CR", `SPI_CR, cr);
    axi_write(`SPI_CR, (32'h1 << `CR_TX_RST_BIT) | (32'h1 << `CR_RX_RST_BIT), 4'hF);
    expect_reg("CR", `SPI_CR, 32'h0);
    report_test("strobes and self-clear", e0);
  endtask

  task automatic test_occupancy();
    int unsigned e0;
    e0 = errors;
    axi_write(`SPI_CR, 32'h0, 4'hF);  // shifter stays idle
    for (int i = 0; i < 3; i++) begin
      axi_write(`SPI_DTR, next_random(), 4'hF);
    end
    expect_reg("TFOR", `SPI_TFOR, 32'h3);
    expect_reg("SR", `SPI_SR, 32'h1);
    axi_write(`SPI_CR, 32'h1 << `CR_TX_RST_BIT, 4'hF);
    expect_reg("TFOR", `SPI_TFOR, 32'h0);
    expect_reg("SR", `SPI_SR, 32'h5);
    report_test("occupancy and flush", e0);
  endtask

  task automatic test_loopback(input logic lsb);
    spi_pkg::spi_data_t  sent[$];
    spi_pkg::spi_data_t  b;
    axi_lite_pkg::data_t d;
    int unsigned         e0;
    e0 = errors;
    mosi_q.delete();
    mosi_bits = 0;
    axi_write(`SPI_SSR, 32'h0, 4'hF);
    axi_write(`SPI_RCLK, 32'h1, 4'hF);
    axi_write(`SPI_CR, (32'(lsb) << `CR_LSB_FIRST_BIT) | (32'h1 << `CR_ENABLE_BIT), 4'hF);
    for (int i = 0; i < 8; i++) begin
      b = spi_pkg::spi_data_t'(next_random());
      sent.push_back(b);
      axi_write(`SPI_DTR, axi_lite_pkg::data_t'(b), 4'hF);
    end
    wait_rx_count(8);
    if (spi_cs_n !== 1'b0) begin
      errors++;
      $display("spi_cs_n_o is high while enabled with SSR 0");
    end
    for (int i = 0; i < 8; i++) begin
      axi_read(`SPI_DRR, d);
      check_byte("DRR", spi_pkg::spi_data_t'(d), sent[i]);
    end
    if (mosi_q.size() != 8) begin
      errors++;
      $display("MOSI monitor captured %0d bytes instead of 8", mosi_q.size());
    end else begin
      for (int i = 0; i < 8; i++) begin
        check_byte("spi_mosi_o", mosi_q[i], lsb ? reverse_bits(sent[i]) : sent[i]);
      end
    end
    report_test(lsb ? "loopback lsb first" : "loopback msb first", e0);
  endtask

  task automatic test_clock_ratio();
    axi_lite_pkg::data_t d;
    spi_pkg::spi_data_t  b;
    int unsigned         gap;
    int unsigned         rises;
    logic                prev;
    int unsigned         e0;
    e0 = errors;
    axi_write(`SPI_CR, 32'h1 << `CR_ENABLE_BIT, 4'hF);
    for (int r = 0; r < 4; r++) begin
      axi_write(`SPI_RCLK, 32'(r), 4'hF);
      b = spi_pkg::spi_data_t'(next_random());
      axi_write(`SPI_DTR, axi_lite_pkg::data_t'(b), 4'hF);
      gap   = 0;
      rises = 0;
      prev  = spi_clk;
      while (rises < 2) begin  // clocks between the first two rises
        @(posedge fixed_clk);
        if (rises == 1) begin
          gap++;
        end
        if (spi_clk && !prev) begin
          rises++;
        end
        prev = spi_clk;
      end
      check_data("spi_clk_o period", axi_lite_pkg::data_t'(gap),
                 axi_lite_pkg::data_t'(1) << (r + 1));
      wait_rx_count(1);
      axi_read(`SPI_DRR, d);
      check_byte("DRR", spi_pkg::spi_data_t'(d), b);
    end
    axi_write(`SPI_CR, 32'h0, 4'hF);
    report_test("clock ratio", e0);
  endtask

  task automatic test_soft_reset();
    int unsigned e0;
    e0 = errors;
    axi_write(`SPI_SSR, 32'h0, 4'hF);
    axi_write(`SPI_RCLK, 32'h5, 4'hF);
    axi_write(`SPI_CR, 32'h1 << `CR_LSB_FIRST_BIT, 4'hF);  // enable stays low
    axi_write(`SPI_DTR, next_random(), 4'hF);
    axi_write(`SPI_SRR, 32'h5, 4'hF);  // wrong key
    expect_reg("SSR", `SPI_SSR, 32'h0);
    expect_reg("RCLK", `SPI_RCLK, 32'h5);
    expect_reg("CR", `SPI_CR, 32'h1 << `CR_LSB_FIRST_BIT);
    expect_reg("TFOR", `SPI_TFOR, 32'h1);
    axi_write(`SPI_SRR, 32'hA, 4'hF);
    check_reset_state();
    report_test("soft reset", e0);
  endtask

  initial begin
    axi_aresetn <= 1'b0;
    axi_awid    <= '0;
    axi_awaddr  <= '0;
    axi_awvalid <= 1'b0;
    axi_wdata   <= '0;
    axi_wstrb   <= '0;
    axi_wvalid  <= 1'b0;
    axi_bready  <= 1'b1;
    axi_arid    <= '0;
    axi_araddr  <= '0;
    axi_arvalid <= 1'b0;
    axi_rready  <= 1'b1;
    repeat (5) @(posedge fixed_clk);
    axi_aresetn <= 1'b1;
    test_reset();
    test_strobes();
    test_occupancy();
    test_loopback(1'b0);
    test_loopback(1'b1);
    test_clock_ratio();
    test_soft_reset();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/axi_lite_pkg.sv
verilog/spi_pkg.sv
verilog/spi_fifo.sv
verilog/spi_shifter.sv
verilog/axi_spi_regs.sv
verilog/axi_spi_top.sv
test/tb_axi_spi.sv

// ==== verilog/axi_lite_pkg.sv ====
`include "axi_spi_defs.svh"

package axi_lite_pkg;

  typedef logic [`AXI_SPI_ADDR_W-1:0]   addr_t;  // byte address
  typedef logic [`AXI_SPI_DATA_W-1:0]   data_t;
  typedef logic [`AXI_SPI_DATA_W/8-1:0] strb_t;  // one bit per byte lane
  typedef logic [`AXI_SPI_ID_W-1:0]     id_t;
  typedef logic [1:0]                   resp_t;

  localparam resp_t RESP_OKAY = 2'b00;  // only response ever given

endpackage

// ==== verilog/axi_spi_defs.svh ====
`ifndef AXI_SPI_DEFS_SVH
`define AXI_SPI_DEFS_SVH

// bus geometry
`define AXI_SPI_ADDR_W    7
`define AXI_SPI_DATA_W    32
`define AXI_SPI_ID_W      4

// spi core geometry
`define SPI_DATA_W        8
`define SPI_FIFO_DEPTH    16
`define SPI_RATIO_W       3   // divider exponent field

// register map, byte offsets
`define SPI_SRR           7'h40
`define SPI_CR            7'h60
`define SPI_SR            7'h64
`define SPI_DTR           7'h68
`define SPI_DRR           7'h6C
`define SPI_SSR           7'h70
`define SPI_TFOR          7'h74
`define SPI_RFOR          7'h78
`define SPI_RCLK          7'h7C

// control register bits
`define CR_ENABLE_BIT     1
`define CR_TX_RST_BIT     5   // self clearing
`define CR_RX_RST_BIT     6   // self clearing
`define CR_LSB_FIRST_BIT  9

// status register bits
`define SR_RX_EMPTY_BIT   0
`define SR_RX_FULL_BIT    1
`define SR_TX_EMPTY_BIT   2
`define SR_TX_FULL_BIT    3

`define SPI_SRR_KEY       32'h0000_000A
`define SPI_UNMAPPED_DATA 32'h6162_6364
`define SPI_SSR_INIT      32'h0000_0001

`endif

// ==== verilog/axi_spi_regs.sv ====
`include "axi_spi_defs.svh"

module axi_spi_regs (
  input  logic                  fixed_clk_i,
  input  logic                  axi_aresetn_i,
  input  axi_lite_pkg::id_t     axi_awid_i,
  input  axi_lite_pkg::addr_t   axi_awaddr_i,
  input  logic                  axi_awvalid_i,
  output logic                  axi_awready_o,
  input  axi_lite_pkg::data_t   axi_wdata_i,
  input  axi_lite_pkg::strb_t   axi_wstrb_i,
  input  logic                  axi_wvalid_i,
  output logic                  axi_wready_o,
  output axi_lite_pkg::id_t     axi_bid_o,
  output axi_lite_pkg::resp_t   axi_bresp_o,
  output logic                  axi_bvalid_o,
  input  logic                  axi_bready_i,
  input  axi_lite_pkg::id_t     axi_arid_i,
  input  axi_lite_pkg::addr_t   axi_araddr_i,
  input  logic                  axi_arvalid_i,
  output logic                  axi_arready_o,
  output axi_lite_pkg::id_t     axi_rid_o,
  output axi_lite_pkg::data_t   axi_rdata_o,
  output axi_lite_pkg::resp_t   axi_rresp_o,
  output logic                  axi_rvalid_o,
  input  logic                  axi_rready_i,
  input  spi_pkg::fifo_status_t tx_status_i,
  input  spi_pkg::fifo_status_t rx_status_i,
  input  spi_pkg::spi_data_t    rx_rdata_i,
  output spi_pkg::spi_cfg_t     cfg_o,
  output logic                  ss_n_o,
  output logic                  tx_push_o,
  output spi_pkg::spi_data_t    tx_wdata_o,
  output logic                  rx_pop_o,
  output logic                  tx_flush_o,
  output logic                  rx_flush_o
);

  typedef enum logic [1:0] {WR_INIT, WR_IDLE, WR_CONTROL, WR_RESP} wr_state_t;
  typedef enum logic {RD_IDLE, RD_RESP} rd_state_t;

  wr_state_t           wr_state;
  rd_state_t           rd_state;
  axi_lite_pkg::data_t cr_q;
  axi_lite_pkg::data_t ssr_q;
  spi_pkg::ratio_t     rclk_q;
  axi_lite_pkg::data_t wmask;       // strobes widened to bits
  axi_lite_pkg::data_t wdata_m;     // unstrobed lanes forced to zero
  axi_lite_pkg::data_t cr_next;
  axi_lite_pkg::data_t rd_mux;
  axi_lite_pkg::addr_t aw_word;
  axi_lite_pkg::addr_t ar_word;
  logic                srst_pend;   // key seen, reset after the response
  logic                wr_start;
  logic                wr_hold;
  logic                rd_hold;

  always_comb begin
    for (int i = 0; i < $bits(axi_lite_pkg::strb_t); i++) begin
      wmask[8*i +: 8] = {8{axi_wstrb_i[i]}};
    end
  end

  assign wdata_m  = axi_wdata_i & wmask;
  assign cr_next  = (cr_q & ~wmask) | wdata_m;
  assign aw_word  = {axi_awaddr_i[`AXI_SPI_ADDR_W-1:2], 2'b00};
  assign ar_word  = {axi_araddr_i[`AXI_SPI_ADDR_W-1:2], 2'b00};
  assign wr_start = axi_awvalid_i & axi_wvalid_i;
  assign wr_hold  = (aw_word == `SPI_DTR) && tx_status_i.full;   // wait for a free slot
  assign rd_hold  = (ar_word == `SPI_DRR) && rx_status_i.empty;  // wait for a word

  assign axi_bresp_o = axi_lite_pkg::RESP_OKAY;
  assign axi_rresp_o = axi_lite_pkg::RESP_OKAY;

  assign ss_n_o = ssr_q[0];
  assign cfg_o  = '{enable:    cr_q[`CR_ENABLE_BIT],
                    lsb_first: cr_q[`CR_LSB_FIRST_BIT],
                    ratio:     rclk_q};

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_state      <= WR_INIT;
      axi_awready_o <= 1'b0;
      axi_wready_o  <= 1'b0;
      axi_bvalid_o  <= 1'b0;
      axi_bid_o     <= '0;
      cr_q          <= '0;
      ssr_q         <= `SPI_SSR_INIT;
      rclk_q        <= '0;
      srst_pend     <= 1'b0;
      tx_push_o     <= 1'b0;
      tx_wdata_o    <= '0;
      tx_flush_o    <= 1'b0;
      rx_flush_o    <= 1'b0;
    end else begin
      tx_push_o  <= 1'b0;  // strobes last one cycle
      tx_flush_o <= 1'b0;
      rx_flush_o <= 1'b0;
      case (wr_state)
        WR_INIT: begin  // entered on hard and soft reset
          cr_q       <= '0;
          ssr_q      <= `SPI_SSR_INIT;
          rclk_q     <= '0;
          srst_pend  <= 1'b0;
          tx_flush_o <= 1'b1;
          rx_flush_o <= 1'b1;
          wr_state   <= WR_IDLE;
        end
        WR_IDLE: begin
          if (wr_start && !wr_hold) begin
            axi_bid_o <= axi_awid_i;
            case (aw_word)
              `SPI_CR: begin
                cr_q       <= cr_next;
                tx_flush_o <= cr_next[`CR_TX_RST_BIT];
                rx_flush_o <= cr_next[`CR_RX_RST_BIT];
              end
              `SPI_SSR:  ssr_q  <= (ssr_q & ~wmask) | wdata_m;
              `SPI_RCLK: rclk_q <= (rclk_q & ~wmask[`SPI_RATIO_W-1:0]) |
                                   wdata_m[`SPI_RATIO_W-1:0];
              `SPI_DTR: begin
                tx_push_o  <= 1'b1;
                tx_wdata_o <= wdata_m[`SPI_DATA_W-1:0];
              end
              `SPI_SRR: srst_pend <= (wdata_m == `SPI_SRR_KEY);
              default: ;  // read-only or unmapped, ignored
            endcase
            if (aw_word == `SPI_CR) begin
              wr_state <= WR_CONTROL;  // extra cycle to clear reset bits
            end else begin
              axi_awready_o <= 1'b1;
              axi_wready_o  <= 1'b1;
              axi_bvalid_o  <= 1'b1;
              wr_state      <= WR_RESP;
            end
          end
        end
        WR_CONTROL: begin
          cr_q[`CR_TX_RST_BIT] <= 1'b0;
          cr_q[`CR_RX_RST_BIT] <= 1'b0;
          axi_awready_o        <= 1'b1;
          axi_wready_o         <= 1'b1;
          axi_bvalid_o         <= 1'b1;
          wr_state             <= WR_RESP;
        end
        WR_RESP: begin
          axi_awready_o <= 1'b0;  // single cycle pulse
          axi_wready_o  <= 1'b0;
          if (axi_bvalid_o && axi_bready_i) begin
            axi_bvalid_o <= 1'b0;
            wr_state     <= srst_pend ? WR_INIT : WR_IDLE;
          end
        end
        default: wr_state <= WR_INIT;
      endcase
    end
  end

  // register view sampled when the read is accepted
  always_comb begin
    rd_mux = '0;
    case (ar_word)
      `SPI_CR:   rd_mux = cr_q;
      `SPI_SR: begin
        rd_mux[`SR_RX_EMPTY_BIT] = rx_status_i.empty;
        rd_mux[`SR_RX_FULL_BIT]  = rx_status_i.full;
        rd_mux[`SR_TX_EMPTY_BIT] = tx_status_i.empty;
        rd_mux[`SR_TX_FULL_BIT]  = tx_status_i.full;
      end
      `SPI_DRR:  rd_mux = axi_lite_pkg::data_t'(rx_rdata_i);
      `SPI_SSR:  rd_mux = ssr_q;
      `SPI_TFOR: rd_mux = axi_lite_pkg::data_t'(tx_status_i.count);
      `SPI_RFOR: rd_mux = axi_lite_pkg::data_t'(rx_status_i.count);
      `SPI_RCLK: rd_mux = axi_lite_pkg::data_t'(rclk_q);
      default:   rd_mux = `SPI_UNMAPPED_DATA;
    endcase
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rd_state      <= RD_IDLE;
      axi_arready_o <= 1'b0;
      axi_rvalid_o  <= 1'b0;
      axi_rid_o     <= '0;
      axi_rdata_o   <= '0;
      rx_pop_o      <= 1'b0;
    end else begin
      rx_pop_o <= 1'b0;
      case (rd_state)
        RD_IDLE: begin
          if (axi_arvalid_i && !rd_hold) begin
            axi_arready_o <= 1'b1;
            axi_rvalid_o  <= 1'b1;
            axi_rid_o     <= axi_arid_i;
            axi_rdata_o   <= rd_mux;
            rx_pop_o      <= (ar_word == `SPI_DRR);  // head already captured
            rd_state      <= RD_RESP;
          end
        end
        RD_RESP: begin
          axi_arready_o <= 1'b0;
          if (axi_rvalid_o && axi_rready_i) begin
            axi_rvalid_o <= 1'b0;
            rd_state     <= RD_IDLE;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/axi_spi_top.sv ====
`include "axi_spi_defs.svh"

module axi_spi_top (
  input  logic                fixed_clk_i,
  input  logic                axi_aresetn_i,
  input  axi_lite_pkg::id_t   axi_awid_i,
  input  axi_lite_pkg::addr_t axi_awaddr_i,
  input  logic                axi_awvalid_i,
  output logic                axi_awready_o,
  input  axi_lite_pkg::data_t axi_wdata_i,
  input  axi_lite_pkg::strb_t axi_wstrb_i,
  input  logic                axi_wvalid_i,
  output logic                axi_wready_o,
  output axi_lite_pkg::id_t   axi_bid_o,
  output axi_lite_pkg::resp_t axi_bresp_o,
  output logic                axi_bvalid_o,
  input  logic                axi_bready_i,
  input  axi_lite_pkg::id_t   axi_arid_i,
  input  axi_lite_pkg::addr_t axi_araddr_i,
  input  logic                axi_arvalid_i,
  output logic                axi_arready_o,
  output axi_lite_pkg::id_t   axi_rid_o,
  output axi_lite_pkg::data_t axi_rdata_o,
  output axi_lite_pkg::resp_t axi_rresp_o,
  output logic                axi_rvalid_o,
  input  logic                axi_rready_i,
  output logic                spi_clk_o,
  output logic                spi_cs_n_o,
  output logic                spi_mosi_o,
  input  logic                spi_miso_i
);

  spi_pkg::spi_cfg_t     cfg;
  spi_pkg::fifo_status_t tx_status;
  spi_pkg::fifo_status_t rx_status;
  spi_pkg::spi_data_t    tx_wdata;   // bus side into tx fifo
  spi_pkg::spi_data_t    tx_rdata;   // tx head into shifter
  spi_pkg::spi_data_t    rx_wdata;   // shifter into rx fifo
  spi_pkg::spi_data_t    rx_rdata;   // rx head to DRR
  logic                  ss_n;
  logic                  tx_push;
  logic                  tx_pop;
  logic                  tx_flush;
  logic                  rx_push;
  logic                  rx_pop;
  logic                  rx_flush;

  axi_spi_regs u_regs (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .axi_awid_i    (axi_awid_i),
    .axi_awaddr_i  (axi_awaddr_i),
    .axi_awvalid_i (axi_awvalid_i),
    .axi_awready_o (axi_awready_o),
    .axi_wdata_i   (axi_wdata_i),
    .axi_wstrb_i   (axi_wstrb_i),
    .axi_wvalid_i  (axi_wvalid_i),
    .axi_wready_o  (axi_wready_o),
    .axi_bid_o     (axi_bid_o),
    .axi_bresp_o   (axi_bresp_o),
    .axi_bvalid_o  (axi_bvalid_o),
    .axi_bready_i  (axi_bready_i),
    .axi_arid_i    (axi_arid_i),
    .axi_araddr_i  (axi_araddr_i),
    .axi_arvalid_i (axi_arvalid_i),
    .axi_arready_o (axi_arready_o),
    .axi_rid_o     (axi_rid_o),
    .axi_rdata_o   (axi_rdata_o),
    .axi_rresp_o   (axi_rresp_o),
    .axi_rvalid_o  (axi_rvalid_o),
    .axi_rready_i  (axi_rready_i),
    .tx_status_i   (tx_status),
    .rx_status_i   (rx_status),
    .rx_rdata_i    (rx_rdata),
    .cfg_o         (cfg),
    .ss_n_o        (ss_n),
    .tx_push_o     (tx_push),
    .tx_wdata_o    (tx_wdata),
    .rx_pop_o      (rx_pop),
    .tx_flush_o    (tx_flush),
    .rx_flush_o    (rx_flush)
  );

  spi_fifo #(
    .DEPTH (`SPI_FIFO_DEPTH)
  ) u_tx_fifo (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .flush_i       (tx_flush),
    .push_i        (tx_push),
    .wdata_i       (tx_wdata),
    .pop_i         (tx_pop),
    .rdata_o       (tx_rdata),
    .status_o      (tx_status)
  );

  spi_fifo #(
    .DEPTH (`SPI_FIFO_DEPTH)
  ) u_rx_fifo (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .flush_i       (rx_flush),
    .push_i        (rx_push),
    .wdata_i       (rx_wdata),
    .pop_i         (rx_pop),
    .rdata_o       (rx_rdata),
    .status_o      (rx_status)
  );

  spi_shifter u_shifter (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .cfg_i         (cfg),
    .ss_n_i        (ss_n),
    .tx_status_i   (tx_status),
    .tx_data_i     (tx_rdata),
    .tx_pop_o      (tx_pop),
    .rx_push_o     (rx_push),
    .rx_data_o     (rx_wdata),
    .spi_clk_o     (spi_clk_o),
    .spi_cs_n_o    (spi_cs_n_o),
    .spi_mosi_o    (spi_mosi_o),
    .spi_miso_i    (spi_miso_i)
  );

endmodule

// ==== verilog/spi_fifo.sv ====
`include "axi_spi_defs.svh"

module spi_fifo #(
  parameter int DEPTH = `SPI_FIFO_DEPTH
) (
  input  logic                  fixed_clk_i,
  input  logic                  axi_aresetn_i,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  spi_pkg::spi_data_t    wdata_i,
  input  logic                  pop_i,
  output spi_pkg::spi_data_t    rdata_o,
  output spi_pkg::fifo_status_t status_o
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
  localparam spi_pkg::occ_t FULL_CNT = spi_pkg::occ_t'(DEPTH);

  spi_pkg::spi_data_t mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  spi_pkg::occ_t      count;
  logic               do_push;
  logic               do_pop;

  assign do_push = push_i && (count != FULL_CNT);  // dropped when full
  assign do_pop  = pop_i && (count != '0);

  always_ff @(posedge fixed_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata_i;
    end
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  assign rdata_o         = mem[rd_ptr];  // head, valid when not empty
  assign status_o.empty  = (count == '0);
  assign status_o.full   = (count == FULL_CNT);
  assign status_o.count  = count;

endmodule

// ==== verilog/spi_pkg.sv ====
`include "axi_spi_defs.svh"

package spi_pkg;

  typedef logic [`SPI_DATA_W-1:0]              spi_data_t;
  typedef logic [`SPI_RATIO_W-1:0]             ratio_t;  // half period is 2**ratio clocks
  typedef logic [$clog2(`SPI_FIFO_DEPTH):0]    occ_t;    // holds 0 up to depth

  // shifter setup taken from CR and RCLK
  typedef struct packed {
    logic   enable;
    logic   lsb_first;
    ratio_t ratio;
  } spi_cfg_t;

  // fifo flags and fill level as seen by the register block
  typedef struct packed {
    logic empty;
    logic full;
    occ_t count;
  } fifo_status_t;

endpackage

// ==== verilog/spi_shifter.sv ====
`include "axi_spi_defs.svh"

module spi_shifter (
  input  logic                  fixed_clk_i,
  input  logic                  axi_aresetn_i,
  input  spi_pkg::spi_cfg_t     cfg_i,
  input  logic                  ss_n_i,
  input  spi_pkg::fifo_status_t tx_status_i,
  input  spi_pkg::spi_data_t    tx_data_i,
  output logic                  tx_pop_o,
  output logic                  rx_push_o,
  output spi_pkg::spi_data_t    rx_data_o,
  output logic                  spi_clk_o,
  output logic                  spi_cs_n_o,
  output logic                  spi_mosi_o,
  input  logic                  spi_miso_i
);

  localparam int DIV_W = 2 ** `SPI_RATIO_W;           // fits the longest half period
  localparam int BIT_W = $clog2(`SPI_DATA_W);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`SPI_DATA_W - 1);

  typedef enum logic {SH_IDLE, SH_SHIFT} sh_state_t;

  sh_state_t          state;
  logic [DIV_W-1:0]   div_cnt;
  logic [DIV_W-1:0]   half_max;
  logic [BIT_W-1:0]   bit_cnt;
  spi_pkg::spi_data_t tx_sh;     // msb always goes out next
  spi_pkg::spi_data_t rx_sh;
  spi_pkg::spi_data_t tx_word;
  logic               half_tick;
  logic               byte_end;  // falling edge after the last bit
  logic               load;

  function automatic spi_pkg::spi_data_t bit_rev(input spi_pkg::spi_data_t d);
    spi_pkg::spi_data_t r;
    for (int i = 0; i < `SPI_DATA_W; i++) begin
      r[i] = d[`SPI_DATA_W-1-i];
    end
    return r;
  endfunction

  assign half_max  = (DIV_W'(1) << cfg_i.ratio) - 1'b1;
  assign half_tick = (div_cnt >= half_max);
  assign byte_end  = (state == SH_SHIFT) && half_tick && spi_clk_o && (bit_cnt == LAST_BIT);
  assign load      = cfg_i.enable && !tx_status_i.empty && ((state == SH_IDLE) || byte_end);
  assign tx_word   = cfg_i.lsb_first ? bit_rev(tx_data_i) : tx_data_i;

  assign tx_pop_o   = load;
  assign spi_mosi_o = tx_sh[`SPI_DATA_W-1];
  assign spi_cs_n_o = ~(cfg_i.enable & ~ss_n_i);

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state     <= SH_IDLE;
      spi_clk_o <= 1'b0;
      div_cnt   <= '0;
      bit_cnt   <= '0;
      tx_sh     <= '0;
      rx_sh     <= '0;
      rx_push_o <= 1'b0;
      rx_data_o <= '0;
    end else begin
      rx_push_o <= 1'b0;
      case (state)
        SH_IDLE: begin
          div_cnt <= '0;
          if (load) begin
            tx_sh   <= tx_word;  // first bit valid before the first rise
            bit_cnt <= '0;
            state   <= SH_SHIFT;
          end
        end
        SH_SHIFT: begin
          if (half_tick) begin
            div_cnt   <= '0;
            spi_clk_o <= ~spi_clk_o;
            if (!spi_clk_o) begin
              rx_sh <= {rx_sh[`SPI_DATA_W-2:0], spi_miso_i};  // rising edge samples
            end else if (byte_end) begin
              rx_push_o <= 1'b1;
              rx_data_o <= cfg_i.lsb_first ? bit_rev(rx_sh) : rx_sh;
              bit_cnt   <= '0;
              if (load) begin
                tx_sh <= tx_word;  // back to back
              end else begin
                tx_sh <= '0;
                state <= SH_IDLE;
              end
            end else begin
              tx_sh   <= tx_sh << 1;  // falling edge shifts
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: state <= SH_IDLE;
      endcase
    end
  end

endmodule
